// ==== soc_io_top.f ====
hw/soc_io_pkg.sv
hw/por_stretch.sv
hw/iomem_arbiter.sv
hw/gpio_regs.sv
hw/scratch_ram.sv
hw/soc_io_top.sv
testbench/tb_clock_gen.sv
testbench/soc_io_properties.sv
testbench/tb_soc_io_top.sv

// ==== Makefile ====
# Verilator build of the soc_io testbench
# override on the command line, e.g. make run BUILD_DIR=obj

VERILATOR ?= verilator
TOP       ?= tb_soc_io_top
BUILD_DIR ?= build
FILELIST  ?= soc_io_top.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from grep, so a missing pass line fails the target
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/tb_soc_io_top.sv ====
`timescale 1ns/1ps

module tb_soc_io_top;

	import soc_io_pkg::*;

	localparam int POR_WIDTH  = 6;
	localparam int RAM_WORDS  = 64;
	localparam int XFER_LIMIT = 20;          // cycles to ready with the bus shared
	localparam int POR_LIMIT  = 200;         // covers the whole reset stretch

	logic  clk_out;
	logic  resetn;
	logic  m0_valid;
	logic  m0_ready;
	logic  m1_valid;
	logic  m1_ready;
	strb_t m0_wstrb;
	strb_t m1_wstrb;
	addr_t m0_addr;
	addr_t m1_addr;
	data_t m0_wdata;
	data_t m0_rdata;
	data_t m1_wdata;
	data_t m1_rdata;
	led_t  buttons;
	led_t  leds;

	int    seed = 61160;                     // $random seed
	int    err_count;
	int    test_count;
	int    test_errs;                        // err_count when the test began
	data_t ref_gpio_out;                     // led register model
	led_t  ref_buttons;
	data_t ref_mem [RAM_WORDS];              // scratch ram model
	string name_q [$];                       // reads waiting for compare
	data_t exp_q [$];
	data_t act_q [$];

	tb_clock_gen i_clk (
		.clk_out (clk_out),
		.resetn  (resetn)
	);

	soc_io_top #(
		.POR_WIDTH (POR_WIDTH),
		.RAM_WORDS (RAM_WORDS)
	) i_dut (
		.clk_out  (clk_out),
		.resetn   (resetn),
		.m0_valid (m0_valid),
		.m0_ready (m0_ready),
		.m0_wstrb (m0_wstrb),
		.m0_addr  (m0_addr),
		.m0_wdata (m0_wdata),
		.m0_rdata (m0_rdata),
		.m1_valid (m1_valid),
		.m1_ready (m1_ready),
		.m1_wstrb (m1_wstrb),
		.m1_addr  (m1_addr),
		.m1_wdata (m1_wdata),
		.m1_rdata (m1_rdata),
		.buttons  (buttons),
		.leds     (leds)
	);

	// ==========================================================================
	// reference model
	// ==========================================================================

	function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
		data_t result;
		result = old_word;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				result[8*i +: 8] = new_word[8*i +: 8]; // strobed lane only
			end
		end
		return result;
	endfunction

	function automatic int ram_index(addr_t addr);
		return int'(addr[31:2]) % RAM_WORDS;         // word wraps modulo depth
	endfunction

	function automatic data_t ref_read(addr_t addr);
		data_t result;
		result = UNMAPPED_RDATA;                     // any other region
		if (addr[31:24] == REGION_RAM) begin
			result = ref_mem[ram_index(addr)];
		end else if (addr[31:24] == REGION_GPIO) begin
			if (addr[23:0] == GPIO_OUT_OFFSET) begin
				result = ref_gpio_out;
			end else if (addr[23:0] == GPIO_IN_OFFSET) begin
				result = data_t'(ref_buttons);       // zero extended
			end else begin
				result = '0;
			end
		end
		return result;
	endfunction

	function automatic void ref_write(addr_t addr, data_t wdata, strb_t wstrb);
		if (addr[31:24] == REGION_RAM) begin
			ref_mem[ram_index(addr)] = merge_bytes(ref_mem[ram_index(addr)], wdata, wstrb);
		end else if (addr[31:24] == REGION_GPIO && addr[23:0] == GPIO_OUT_OFFSET) begin
			ref_gpio_out = merge_bytes(ref_gpio_out, wdata, wstrb);
		end
	endfunction

	// ==========================================================================
	// checking and reporting
	// ==========================================================================

	task automatic check_value(input string name, input data_t expected, input data_t actual);
		if (expected !== actual) begin
			err_count++;
			$display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
		end
	endtask

	// queued read results compared one clock after they arrive
	always @(posedge clk_out) begin
		while (act_q.size() > 0) begin
			check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
		end
	end

	task automatic begin_test();
		test_errs = err_count;
	endtask

	task automatic end_test(input string name);
		@(posedge clk_out);                      // let pending compares drain
		#1;
		test_count++;
		$display("test %s: %0d errors", name, err_count - test_errs);
	endtask

	// ==========================================================================
	// bus master tasks
	// ==========================================================================

	function automatic logic ready_of(int m);
		return (m == 0) ? m0_ready : m1_ready;
	endfunction

	task automatic bus_xfer(input int m, input addr_t addr, input data_t wdata,
	                        input strb_t wstrb, input int limit,
	                        output data_t rdata, output int cycles);
		@(posedge clk_out);
		#1;
		if (m == 0) begin
			m0_valid = 1'b1;
			m0_addr  = addr;
			m0_wdata = wdata;
			m0_wstrb = wstrb;
		end else begin
			m1_valid = 1'b1;
			m1_addr  = addr;
			m1_wdata = wdata;
			m1_wstrb = wstrb;
		end
		cycles = 0;
		@(negedge clk_out);                      // sample mid cycle
		while (ready_of(m) !== 1'b1 && cycles < limit) begin
			cycles++;
			@(negedge clk_out);
		end
		if (ready_of(m) !== 1'b1) begin
			$display("timeout: master %0d got no ready for address %08h", m, addr);
			$display("ERRORS FOUND");
			$finish;
		end else begin
			rdata = (m == 0) ? m0_rdata : m1_rdata;
			@(posedge clk_out);
			#1;
			if (m == 0) begin
				m0_valid = 1'b0;                 // cycle after ready
			end else begin
				m1_valid = 1'b0;
			end
		end
	endtask

	task automatic bus_write(input int m, input addr_t addr, input data_t wdata,
	                         input strb_t wstrb, input int limit, output int cycles);
		data_t rd;
		ref_write(addr, wdata, wstrb);
		bus_xfer(m, addr, wdata, wstrb, limit, rd, cycles);
	endtask

	task automatic bus_read(input int m, input addr_t addr, input string name);
		data_t expected;
		data_t rd;
		int    cycles;
		expected = ref_read(addr);               // model value at issue
		bus_xfer(m, addr, '0, '0, XFER_LIMIT, rd, cycles);
		name_q.push_back(name);
		exp_q.push_back(expected);
		act_q.push_back(rd);
	endtask

	// m0 uses the even words and m1 the odd words
	task automatic contend(input int m);
		addr_t addr;
		int    cycles;
		for (int i = 0; i < 6; i++) begin
			addr = {REGION_RAM, 24'(4 * (2 * i + m))};
			bus_write(m, addr, $random(seed), strb_t'($random(seed)) | 4'h1, XFER_LIMIT, cycles);
			bus_read(m, addr, "contention");
		end
	endtask

	// ==========================================================================
	// stimulus
	// ==========================================================================

	initial begin
		data_t wdata;
		strb_t strb;
		addr_t addr;
		int    cycles;
		int    n;
		logic  leds_early;

		err_count    = 0;
		test_count   = 0;
		m0_valid     = 1'b0;
		m0_addr      = '0;
		m0_wdata     = '0;
		m0_wstrb     = '0;
		m1_valid     = 1'b0;
		m1_addr      = '0;
		m1_wdata     = '0;
		m1_wstrb     = '0;
		buttons      = '0;
		ref_buttons  = '0;
		ref_gpio_out = '0;                       // led register resets to zero

		n = 0;
		while (resetn !== 1'b1 && n < 100) begin
			n++;
			@(posedge clk_out);
		end
		if (resetn !== 1'b1) begin
			$display("timeout: external reset was never released");
			$display("ERRORS FOUND");
			$finish;
		end

		// write issued at once has to wait out the reset stretch
		begin_test();
		leds_early = 1'b0;
		wdata      = $random(seed);
		fork
			bus_write(0, {REGION_GPIO, GPIO_OUT_OFFSET}, wdata, 4'hf, POR_LIMIT, cycles);
			begin
				n = 0;
				while (m0_ready !== 1'b1 && n < POR_LIMIT) begin
					if (leds !== '0) begin
						leds_early = 1'b1;       // leds moved before ready
					end
					n++;
					@(negedge clk_out);
				end
			end
		join
		check_value("por_leds_held", '0, data_t'(leds_early));
		check_value("por_stretch", 32'd1, data_t'(cycles >= 2**POR_WIDTH - 1));
		check_value("por_leds", data_t'(ref_gpio_out[3:0]), data_t'(leds));
		end_test("reset_stretch");

		// gpio byte strobes
		begin_test();
		for (int i = 0; i < 8; i++) begin
			wdata = $random(seed);
			strb  = strb_t'($random(seed));
			bus_write(i % 2, {REGION_GPIO, GPIO_OUT_OFFSET}, wdata, strb, XFER_LIMIT, cycles);
			check_value("gpio_latency", 32'd2, data_t'(cycles)); // bus was free
			check_value("gpio_leds", data_t'(ref_gpio_out[3:0]), data_t'(leds));
			bus_read(i % 2, {REGION_GPIO, GPIO_OUT_OFFSET}, "gpio_strobe");
		end
		end_test("gpio_strobe");

		// buttons through the synchronizer
		begin_test();
		for (int i = 0; i < 4; i++) begin
			@(posedge clk_out);
			#1;
			buttons     = led_t'($random(seed));
			ref_buttons = buttons;
			repeat (3) @(posedge clk_out);       // past both sync flops
			bus_read(i % 2, {REGION_GPIO, GPIO_IN_OFFSET}, "buttons");
		end
		end_test("buttons");

		// fill the scratch ram first since its contents are not reset
		begin_test();
		for (int k = 0; k < RAM_WORDS; k++) begin
			addr = {REGION_RAM, 24'(4 * k)};
			bus_write(k % 2, addr, 32'h5a5a_0000 + 32'(k), 4'hf, XFER_LIMIT, cycles);
		end
		for (int i = 0; i < 24; i++) begin
			addr = {REGION_RAM, 24'($random(seed)) & 24'h00_0ffc}; // up to 16x depth
			bus_write(i % 2, addr, $random(seed), strb_t'($random(seed)), XFER_LIMIT, cycles);
			addr = {REGION_RAM, 24'($random(seed)) & 24'h00_0ffc};
			bus_read((i + 1) % 2, addr, "ram_random");
		end
		addr = {REGION_RAM, 24'(4 * (RAM_WORDS + 5))};
		bus_write(0, addr, $random(seed), 4'hf, XFER_LIMIT, cycles);
		bus_read(1, {REGION_RAM, 24'(4 * 5)}, "ram_wrap");
		end_test("scratch_ram");

		// unmapped accesses whose low bits alias gpio and ram word 0
		begin_test();
		bus_read(0, 32'h0100_0010, "unmapped_read");
		bus_read(1, 32'h7f00_0000, "unmapped_read");
		bus_write(1, {8'h07, GPIO_OUT_OFFSET}, ~ref_gpio_out, 4'hf, XFER_LIMIT, cycles);
		bus_write(0, 32'h0400_0000, 32'hdead_beef, 4'hf, XFER_LIMIT, cycles);
		bus_read(0, {REGION_GPIO, GPIO_OUT_OFFSET}, "unmapped_write");
		bus_read(1, {REGION_RAM, 24'h00_0000}, "unmapped_write");
		check_value("unmapped_leds", data_t'(ref_gpio_out[3:0]), data_t'(leds));
		end_test("unmapped");

		// both masters request in the same cycle
		begin_test();
		fork
			contend(0);
			contend(1);
		join
		end_test("contention");

		$display("done: %0d tests, %0d errors", test_count, err_count);
		if (err_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== testbench/soc_io_properties.sv ====
`timescale 1ns/1ps

module soc_io_properties (
	input logic                   clk_out,
	input logic                   resetn,      // stretched reset of the arbiter
	input logic                   m0_valid,
	input logic                   m0_ready,
	input logic                   m1_valid,
	input logic                   m1_ready,
	input soc_io_pkg::arb_state_t state
);

	import soc_io_pkg::*;

	// ==========================================================================
	// handshake
	// ==========================================================================

	a_single_ready: assert property (@(posedge clk_out) disable iff (!resetn)
		!(m0_ready && m1_ready))
		else $error("ready high on both masters in one cycle");

	a_m0_ready_valid: assert property (@(posedge clk_out) disable iff (!resetn)
		m0_ready |-> m0_valid)
		else $error("m0 got ready without valid");

	a_m1_ready_valid: assert property (@(posedge clk_out) disable iff (!resetn)
		m1_ready |-> m1_valid)
		else $error("m1 got ready without valid");

	// ==========================================================================
	// arbitration
	// ==========================================================================

	// a master still waiting when the other transfer ends is granted next
	a_m0_not_starved: assert property (@(posedge clk_out) disable iff (!resetn)
		(state == ARB_IDLE && $past(state) == ARB_M1 && m0_valid)
		|=> (state == ARB_M0))
		else $error("m1 got a second grant while m0 waited");

	a_m1_not_starved: assert property (@(posedge clk_out) disable iff (!resetn)
		(state == ARB_IDLE && $past(state) == ARB_M0 && m1_valid)
		|=> (state == ARB_M1))
		else $error("m0 got a second grant while m1 waited");

	a_lone_request: assert property (@(posedge clk_out) disable iff (!resetn)
		(state == ARB_IDLE && (m0_valid != m1_valid))
		|=> (state == (($past(m0_valid)) ? ARB_M0 : ARB_M1)))
		else $error("single request was not granted");

endmodule

bind iomem_arbiter soc_io_properties i_props (
	.clk_out  (clk_out),
	.resetn   (resetn),
	.m0_valid (m0_valid),
	.m0_ready (m0_ready),
	.m1_valid (m1_valid),
	.m1_ready (m1_ready),
	.state    (state)
);

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 8,          // clk_out period
	parameter int RESET_CYCLES = 16          // external reset length
) (
	output logic clk_out,
	output logic resetn
);

	initial begin
		clk_out = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clk_out = ~clk_out;                  // free running
		end
	end

	initial begin
		resetn = 1'b0;                           // board reset held low
		repeat (RESET_CYCLES) @(posedge clk_out);
		#1;
		resetn = 1'b1;                           // released just after an edge
	end

endmodule

// ==== hw/soc_io_top.sv ====
`timescale 1ns/1ps

module soc_io_top #(
	parameter int POR_WIDTH = 6,             // reset stretch counter width
	parameter int RAM_WORDS = 64             // scratch ram depth
) (
	input  logic              clk_out,
	input  logic              resetn,

	// master 0
	input  logic              m0_valid,
	output logic              m0_ready,
	input  soc_io_pkg::strb_t m0_wstrb,
	input  soc_io_pkg::addr_t m0_addr,
	input  soc_io_pkg::data_t m0_wdata,
	output soc_io_pkg::data_t m0_rdata,

	// master 1
	input  logic              m1_valid,
	output logic              m1_ready,
	input  soc_io_pkg::strb_t m1_wstrb,
	input  soc_io_pkg::addr_t m1_addr,
	input  soc_io_pkg::data_t m1_wdata,
	output soc_io_pkg::data_t m1_rdata,

	// board io
	input  soc_io_pkg::led_t  buttons,
	output soc_io_pkg::led_t  leds
);

	import soc_io_pkg::*;

	logic  sys_resetn;                       // stretched reset for the subsystem

	addr_t s_addr;                           // shared slave lines
	data_t s_wdata;
	strb_t s_wstrb;

	logic  gpio_valid;
	logic  gpio_ready;
	data_t gpio_rdata;

	logic  ram_valid;
	logic  ram_ready;
	data_t ram_rdata;

	// ==========================================================================
	// reset
	// ==========================================================================

	por_stretch #(
		.POR_WIDTH (POR_WIDTH)
	) i_por (
		.clk_out    (clk_out),
		.resetn     (resetn),
		.sys_resetn (sys_resetn)
	);

	// ==========================================================================
	// bus and peripherals
	// ==========================================================================

	iomem_arbiter i_arb (
		.clk_out    (clk_out),
		.resetn     (sys_resetn),
		.m0_valid   (m0_valid),
		.m0_ready   (m0_ready),
		.m0_wstrb   (m0_wstrb),
		.m0_addr    (m0_addr),
		.m0_wdata   (m0_wdata),
		.m0_rdata   (m0_rdata),
		.m1_valid   (m1_valid),
		.m1_ready   (m1_ready),
		.m1_wstrb   (m1_wstrb),
		.m1_addr    (m1_addr),
		.m1_wdata   (m1_wdata),
		.m1_rdata   (m1_rdata),
		.s_addr     (s_addr),
		.s_wdata    (s_wdata),
		.s_wstrb    (s_wstrb),
		.gpio_valid (gpio_valid),
		.gpio_ready (gpio_ready),
		.gpio_rdata (gpio_rdata),
		.ram_valid  (ram_valid),
		.ram_ready  (ram_ready),
		.ram_rdata  (ram_rdata)
	);

	gpio_regs i_gpio (
		.clk_out (clk_out),
		.resetn  (sys_resetn),
		.valid   (gpio_valid),
		.ready   (gpio_ready),
		.addr    (s_addr),
		.wdata   (s_wdata),
		.wstrb   (s_wstrb),
		.rdata   (gpio_rdata),
		.buttons (buttons),
		.leds    (leds)
	);

	scratch_ram #(
		.RAM_WORDS (RAM_WORDS)
	) i_ram (
		.clk_out (clk_out),
		.resetn  (sys_resetn),
		.valid   (ram_valid),
		.ready   (ram_ready),
		.addr    (s_addr),
		.wdata   (s_wdata),
		.wstrb   (s_wstrb),
		.rdata   (ram_rdata)
	);

endmodule

// ==== hw/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram #(
	parameter int RAM_WORDS = 64             // depth in words, power of two
) (
	input  logic              clk_out,
	input  logic              resetn,
	input  logic              valid,
	output logic              ready,
	input  soc_io_pkg::addr_t addr,
	input  soc_io_pkg::data_t wdata,
	input  soc_io_pkg::strb_t wstrb,
	output soc_io_pkg::data_t rdata
);

	import soc_io_pkg::*;

	localparam int AW = $clog2(RAM_WORDS);   // word index width

	data_t          mem [RAM_WORDS];         // contents survive reset
	logic [AW-1:0]  word_idx;
	logic           accept;

	assign word_idx = addr[AW+1:2];          // word bits, wraps modulo depth
	assign accept   = valid && !ready;

	// ready pulse, the only control state here
	always_ff @(posedge clk_out) begin
		if (!resetn) begin
			ready <= 1'b0;
		end else begin
			ready <= accept;
		end
	end

	// array access, read returns the word before the write
	always_ff @(posedge clk_out) begin
		if (accept) begin
			rdata <= mem[word_idx];
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i]) begin
					mem[word_idx][8*i +: 8] <= wdata[8*i +: 8]; // strobed lane
				end
			end
		end
	end

endmodule

// ==== hw/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs (
	input  logic              clk_out,
	input  logic              resetn,
	input  logic              valid,
	output logic              ready,
	input  soc_io_pkg::addr_t addr,
	input  soc_io_pkg::data_t wdata,
	input  soc_io_pkg::strb_t wstrb,
	output soc_io_pkg::data_t rdata,
	input  soc_io_pkg::led_t  buttons,
	output soc_io_pkg::led_t  leds
);

	import soc_io_pkg::*;

	data_t gpio_out;                         // output register
	led_t  btn_meta;                         // first sync stage
	led_t  btn_sync;                         // second sync stage
	logic  accept;                           // new access this cycle

	assign accept = valid && !ready;         // ignore valid during own ready

	// two flop synchronizer for the push buttons
	always_ff @(posedge clk_out) begin
		if (!resetn) begin
			btn_meta <= '0;
			btn_sync <= '0;
		end else begin
			btn_meta <= buttons;
			btn_sync <= btn_meta;
		end
	end

	// one cycle ready pulse
	always_ff @(posedge clk_out) begin
		if (!resetn) begin
			ready <= 1'b0;
		end else begin
			ready <= accept;
		end
	end

	// byte lane writes, button register is read only
	always_ff @(posedge clk_out) begin
		if (!resetn) begin
			gpio_out <= '0;
		end else if (accept && addr[23:0] == GPIO_OUT_OFFSET) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i]) begin
					gpio_out[8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// read data, old register value on a write
	always_ff @(posedge clk_out) begin
		if (accept) begin
			case (addr[23:0])
				GPIO_OUT_OFFSET: rdata <= gpio_out;
				GPIO_IN_OFFSET:  rdata <= data_t'(btn_sync); // zero extended
				default:         rdata <= '0;
			endcase
		end
	end

	assign leds = gpio_out[3:0];             // low nibble drives the leds

endmodule

// ==== hw/iomem_arbiter.sv ====
`timescale 1ns/1ps

module iomem_arbiter (
	input  logic              clk_out,
	input  logic              resetn,

	// master 0, processor port
	input  logic              m0_valid,
	output logic              m0_ready,
	input  soc_io_pkg::strb_t m0_wstrb,
	input  soc_io_pkg::addr_t m0_addr,
	input  soc_io_pkg::data_t m0_wdata,
	output soc_io_pkg::data_t m0_rdata,

	// master 1, debug / host port
	input  logic              m1_valid,
	output logic              m1_ready,
	input  soc_io_pkg::strb_t m1_wstrb,
	input  soc_io_pkg::addr_t m1_addr,
	input  soc_io_pkg::data_t m1_wdata,
	output soc_io_pkg::data_t m1_rdata,

	// shared slave lines
	output soc_io_pkg::addr_t s_addr,
	output soc_io_pkg::data_t s_wdata,
	output soc_io_pkg::strb_t s_wstrb,

	// gpio slave
	output logic              gpio_valid,
	input  logic              gpio_ready,
	input  soc_io_pkg::data_t gpio_rdata,

	// ram slave
	output logic              ram_valid,
	input  logic              ram_ready,
	input  soc_io_pkg::data_t ram_rdata
);

	import soc_io_pkg::*;

	arb_state_t state;                       // current grant
	logic       last_owner;                  // 1 = m1 had the last grant
	logic       own_valid;                   // valid of the granted master
	logic       unmapped_ready;              // local completion, unmapped region
	region_t    region;
	logic       is_gpio;
	logic       is_ram;
	logic       sel_ready;                   // ready of the addressed target
	data_t      sel_rdata;

	// ==========================================================================
	// grant fsm, round robin on last_owner
	// ==========================================================================

	always_ff @(posedge clk_out) begin
		if (!resetn) begin
			state      <= ARB_IDLE;
			last_owner <= 1'b1;              // so m0 wins first
		end else begin
			case (state)
				ARB_IDLE: begin
					if (m0_valid && (!m1_valid || last_owner)) begin
						state      <= ARB_M0;    // m0 alone, or m0's turn
						last_owner <= 1'b0;
					end else if (m1_valid) begin
						state      <= ARB_M1;
						last_owner <= 1'b1;
					end
				end
				default: begin
					if (sel_ready) begin
						state <= ARB_IDLE;       // one idle cycle between grants
					end
				end
			endcase
		end
	end

	// ==========================================================================
	// forward the owner, decode region
	// ==========================================================================

	assign own_valid = (state == ARB_M0) ? m0_valid :
	                   (state == ARB_M1) ? m1_valid : 1'b0;

	assign s_addr  = (state == ARB_M1) ? m1_addr  : m0_addr;
	assign s_wdata = (state == ARB_M1) ? m1_wdata : m0_wdata;
	assign s_wstrb = (state == ARB_M1) ? m1_wstrb : m0_wstrb;

	assign region  = s_addr[31:24];
	assign is_gpio = (region == REGION_GPIO);
	assign is_ram  = (region == REGION_RAM);

	assign gpio_valid = own_valid && is_gpio;
	assign ram_valid  = own_valid && is_ram;

	// unmapped access completes here, one cycle after the grant
	always_ff @(posedge clk_out) begin
		if (!resetn) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= own_valid && !is_gpio && !is_ram && !unmapped_ready;
		end
	end

	// ==========================================================================
	// response path back to the owner
	// ==========================================================================

	always_comb begin
		if (is_gpio) begin
			sel_ready = gpio_ready;
			sel_rdata = gpio_rdata;
		end else if (is_ram) begin
			sel_ready = ram_ready;
			sel_rdata = ram_rdata;
		end else begin
			sel_ready = unmapped_ready;
			sel_rdata = UNMAPPED_RDATA;
		end
	end

	assign m0_ready = (state == ARB_M0) && sel_ready;
	assign m1_ready = (state == ARB_M1) && sel_ready;
	assign m0_rdata = sel_rdata;             // only meaningful with m0_ready
	assign m1_rdata = sel_rdata;

endmodule

// ==== hw/por_stretch.sv ====
`timescale 1ns/1ps

module por_stretch #(
	parameter int POR_WIDTH = 6              // stretch = 2**POR_WIDTH - 1 cycles
) (
	input  logic clk_out,
	input  logic resetn,                     // external reset
	output logic sys_resetn                  // stretched internal reset
);

	logic [POR_WIDTH-1:0] reset_cnt;         // saturating up counter
	logic                 cnt_full;

	assign cnt_full = &reset_cnt;            // all ones ends the stretch

	always_ff @(posedge clk_out) begin
		if (!resetn) begin
			reset_cnt <= '0;                 // restart on every external reset
		end else if (!cnt_full) begin
			reset_cnt <= reset_cnt + 1'b1;   // count until saturated
		end
	end

	// released once the counter holds all ones
	assign sys_resetn = cnt_full;

endmodule

// ==== hw/soc_io_pkg.sv ====
package soc_io_pkg;

	// ==========================================================================
	// bus widths
	// ==========================================================================

	typedef logic [31:0] addr_t;             // byte address
	typedef logic [31:0] data_t;             // read / write word
	typedef logic [3:0]  strb_t;             // one bit per byte lane, zero = read
	typedef logic [7:0]  region_t;           // addr[31:24]
	typedef logic [3:0]  led_t;              // leds and buttons

	// ==========================================================================
	// address map
	// ==========================================================================

	localparam region_t REGION_RAM  = 8'h00; // scratch ram
	localparam region_t REGION_GPIO = 8'h03; // gpio block, same as board

	localparam logic [23:0] GPIO_OUT_OFFSET = 24'h00_0000; // led output reg
	localparam logic [23:0] GPIO_IN_OFFSET  = 24'h00_0004; // button input reg

	localparam data_t UNMAPPED_RDATA = 32'h0000_0000;      // any other region

	// ==========================================================================
	// arbiter fsm
	// ==========================================================================

	typedef enum logic [1:0] {
		ARB_IDLE,                            // sampling requests
		ARB_M0,                              // m0 owns the bus
		ARB_M1                               // m1 owns the bus
	} arb_state_t;

endpackage
